// File: sources.f
+incdir+include
logic/heapPkg.sv
logic/heapAllocator.sv
logic/requestValidator.sv
logic/elementStore.sv
logic/heapMemory.sv
sim/heapChecker.sv
sim/heapTest.sv

// File: Makefile
# Verilator build and run of the heap memory testbench

SIM = obj_dir/VheapTest

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module heapTest

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

// File: sim/heapTest.sv
//------------------
// Heap testbench top
// Clock, reset, stimulus table and request loop
//------------------

`timescale 1ns/1ps

module heapTest import heapPkg::*; ();

  typedef struct {
    heapOp       op;
    arrayId      arr;
    elementIndex index;
    element      data;
    element      expData;
    heapError    expError;
    logic        burst;                                // Next row follows at once
  } stepEntry;

  logic        clock;
  logic        reset;
  logic        requestValid;
  heapOp       requestOp;
  arrayId      requestArray;
  elementIndex requestIndex;
  element      requestData;
  logic        responseValid;
  element      responseData;
  heapError    responseError;
  logic        expectValid;                            // To the checker
  int          expectTest;
  element      expectData;
  heapError    expectError;
  logic        reportNow;
  int          pendingCount;
  int          failCount;
  logic        timedOut;
  stepEntry    steps [$];                              // Stimulus table

  heapMemory dut0 (
    .clock, .reset, .requestValid, .requestOp, .requestArray, .requestIndex,
    .requestData, .responseValid, .responseData, .responseError
  );

  heapChecker checker0 (
    .clock, .reset, .expectValid, .expectTest, .expectData, .expectError,
    .responseValid, .responseData, .responseError, .reportNow, .pendingCount,
    .failCount
  );

  always #10 clock = ~clock;                           // 20 ns period

  task addStep(input heapOp op, input arrayId arr, input elementIndex index,
               input element data, input element expData, input heapError expError,
               input logic burst);
    stepEntry s;
    s.op       = op;
    s.arr      = arr;
    s.index    = index;
    s.data     = data;
    s.expData  = expData;
    s.expError = expError;
    s.burst    = burst;
    steps.push_back(s);
  endtask

  task buildTable;
    // Allocation until out of memory
    addStep(opRead,     2'd0, 2'd0, 12'h000, 12'h000, errNeverAllocated, 1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h000, errNone,           1'b0);
    addStep(opSize,     2'd1, 2'd0, 12'h000, 12'h000, errNeverAllocated, 1'b0);
    addStep(opFree,     2'd2, 2'd0, 12'h000, 12'h000, errNeverAllocated, 1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h001, errNone,           1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h002, errNone,           1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h003, errNone,           1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h000, errOutOfMemory,    1'b0);
    // Write grows the size
    addStep(opWrite,    2'd0, 2'd2, 12'h123, 12'h123, errNone,           1'b0);
    addStep(opSize,     2'd0, 2'd0, 12'h000, 12'h003, errNone,           1'b0);
    addStep(opRead,     2'd0, 2'd3, 12'h000, 12'h000, errOutOfBounds,    1'b0);
    addStep(opRead,     2'd0, 2'd2, 12'h000, 12'h123, errNone,           1'b0);
    // Push and pop on array 1
    addStep(opPush,     2'd1, 2'd0, 12'h011, 12'h011, errNone,           1'b0);
    addStep(opPush,     2'd1, 2'd0, 12'h022, 12'h022, errNone,           1'b0);
    addStep(opPush,     2'd1, 2'd0, 12'h033, 12'h033, errNone,           1'b0);
    addStep(opPush,     2'd1, 2'd0, 12'h044, 12'h044, errNone,           1'b0);
    addStep(opPush,     2'd1, 2'd0, 12'h055, 12'h000, errFull,           1'b0);
    addStep(opPop,      2'd1, 2'd0, 12'h000, 12'h044, errNone,           1'b0);
    addStep(opPop,      2'd1, 2'd0, 12'h000, 12'h033, errNone,           1'b0);
    addStep(opPop,      2'd1, 2'd0, 12'h000, 12'h022, errNone,           1'b0);
    addStep(opPop,      2'd1, 2'd0, 12'h000, 12'h011, errNone,           1'b0);
    addStep(opPop,      2'd1, 2'd0, 12'h000, 12'h000, errEmpty,          1'b0);
    // Add and add after, wrapping at 12 bits
    addStep(opWrite,    2'd2, 2'd0, 12'hff0, 12'hff0, errNone,           1'b0);
    addStep(opAdd,      2'd2, 2'd0, 12'h020, 12'h010, errNone,           1'b0);
    addStep(opAddAfter, 2'd2, 2'd0, 12'h005, 12'h010, errNone,           1'b0);
    addStep(opAddAfter, 2'd2, 2'd0, 12'hfff, 12'h015, errNone,           1'b0);
    addStep(opRead,     2'd2, 2'd0, 12'h000, 12'h014, errNone,           1'b0);
    addStep(opAdd,      2'd2, 2'd1, 12'h005, 12'h000, errOutOfBounds,    1'b0);
    // Free and reuse, newest freed first
    addStep(opPush,     2'd1, 2'd0, 12'h066, 12'h066, errNone,           1'b0);
    addStep(opFree,     2'd1, 2'd0, 12'h000, 12'h000, errNone,           1'b0);
    addStep(opFree,     2'd2, 2'd0, 12'h000, 12'h000, errNone,           1'b0);
    addStep(opRead,     2'd2, 2'd0, 12'h000, 12'h000, errFreed,          1'b0);
    addStep(opFree,     2'd1, 2'd0, 12'h000, 12'h000, errFreed,          1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h002, errNone,           1'b0);
    addStep(opSize,     2'd2, 2'd0, 12'h000, 12'h000, errNone,           1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h001, errNone,           1'b0);
    addStep(opSize,     2'd1, 2'd0, 12'h000, 12'h000, errNone,           1'b0);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h000, errOutOfMemory,    1'b0);
    // Back to back burst on array 3
    addStep(opPush,     2'd3, 2'd0, 12'h100, 12'h100, errNone,           1'b1);
    addStep(opPush,     2'd3, 2'd0, 12'h200, 12'h200, errNone,           1'b1);
    addStep(opAdd,      2'd3, 2'd0, 12'h00f, 12'h10f, errNone,           1'b1);
    addStep(opAddAfter, 2'd3, 2'd1, 12'h001, 12'h200, errNone,           1'b1);
    addStep(opPop,      2'd3, 2'd0, 12'h000, 12'h201, errNone,           1'b1);
    addStep(opSize,     2'd3, 2'd0, 12'h000, 12'h001, errNone,           1'b1);
    addStep(opFree,     2'd3, 2'd0, 12'h000, 12'h000, errNone,           1'b1);
    addStep(opAlloc,    2'd0, 2'd0, 12'h000, 12'h003, errNone,           1'b1);
    addStep(opSize,     2'd3, 2'd0, 12'h000, 12'h000, errNone,           1'b0);
  endtask

  // Wait until every issued request has its response
  task waitIdle;
    int waited;
    waited = 0;
    while (pendingCount != 0 && waited < 10) begin
      @(posedge clock);
      #1;
      waited++;
    end
    if (pendingCount != 0) begin
      $display("Timeout waiting 10 cycles for a response from the heap");
      timedOut = 1'b1;
    end
  endtask

  //------------------
  // Stimulus
  //------------------
  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    requestValid = 1'b0;
    requestOp    = opAlloc;
    requestArray = '0;
    requestIndex = '0;
    requestData  = '0;
    expectValid  = 1'b0;
    expectTest   = 0;
    expectData   = '0;
    expectError  = errNone;
    reportNow    = 1'b0;
    timedOut     = 1'b0;
    buildTable();
    repeat (5) @(posedge clock);                       // Reset for 5 cycles
    #1;
    reset = 1'b0;
    for (int i = 0; i < steps.size() && !timedOut; i++) begin
      requestValid = 1'b1;                             // 1 ns after the edge
      requestOp    = steps[i].op;
      requestArray = steps[i].arr;
      requestIndex = steps[i].index;
      requestData  = steps[i].data;
      expectValid  = 1'b1;
      expectTest   = i + 1;
      expectData   = steps[i].expData;
      expectError  = steps[i].expError;
      @(posedge clock);
      #1;
      requestValid = 1'b0;
      expectValid  = 1'b0;
      if (!steps[i].burst) waitIdle();
    end
    if (!timedOut) waitIdle();                         // Drain the pipeline
    reportNow = 1'b1;
    #1;
    if (!timedOut && failCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: sim/heapChecker.sv
//------------------
// Response checker
// Queue of expected responses, timing and value checks
//------------------

`timescale 1ns/1ps

module heapChecker import heapPkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     expectValid,                        // Request issued this cycle
  input  int       expectTest,                         // Table row number
  input  element   expectData,
  input  heapError expectError,
  input  logic     responseValid,                      // From the DUT
  input  element   responseData,
  input  heapError responseError,
  input  logic     reportNow,                          // Print closing counts
  output int       pendingCount,                       // Responses still owed
  output int       failCount
);

  typedef struct {
    int       test;
    int       due;                                     // Cycle the response belongs to
    element   data;
    heapError error;
  } expectEntry;

  expectEntry pending [$];                             // Oldest request first
  int         cycle;                                   // Edges since reset
  int         testCount;

  task checkResponse(input expectEntry e);
    logic ok;
    ok = 1'b1;
    if (responseData !== e.data) begin
      $display("MISMATCH test %0d responseData got %h expected %h",
               e.test, responseData, e.data);
      ok = 1'b0;
    end
    if (responseError !== e.error) begin
      $display("MISMATCH test %0d responseError got %h expected %h",
               e.test, responseError, e.error);
      ok = 1'b0;
    end
    if (cycle != e.due) begin                          // Early response
      $display("Test %0d answered at cycle %0d instead of cycle %0d",
               e.test, cycle, e.due);
      ok = 1'b0;
    end
    testCount++;
    if (ok) begin
      $display("Test %0d passed", e.test);
    end else begin
      $display("Test %0d failed", e.test);
      failCount++;
    end
  endtask

  //------------------
  // Watch the DUT at every edge
  //------------------
  always @(posedge clock) begin : watch
    expectEntry entry;
    if (reset) begin
      cycle     = 0;
      testCount = 0;
      failCount = 0;
      pending.delete();
    end else begin
      cycle = cycle + 1;
      if (responseValid) begin
        if (pending.size() == 0) begin
          $display("Response at cycle %0d with no request outstanding", cycle);
          failCount++;
        end else begin
          checkResponse(pending.pop_front());
        end
      end
      if (pending.size() != 0 && pending[0].due < cycle) begin // Late or lost
        $display("Test %0d got no response two cycles after its request", pending[0].test);
        void'(pending.pop_front());
        testCount++;
        failCount++;
      end
      if (expectValid) begin
        entry.test  = expectTest;
        entry.due   = cycle + 2;                       // Fixed pipeline latency
        entry.data  = expectData;
        entry.error = expectError;
        pending.push_back(entry);
      end
    end
    pendingCount = pending.size();
  end

  always @(posedge reportNow) begin
    $display("Tests run %0d, errors %0d", testCount, failCount);
  end

endmodule

// File: logic/heapMemory.sv
//------------------
// Heap memory top
// Validator, allocator and element store in a
// two stage pipeline
//------------------

`timescale 1ns/1ps

module heapMemory import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        requestValid,
  input  heapOp       requestOp,
  input  arrayId      requestArray,
  input  elementIndex requestIndex,
  input  element      requestData,
  output logic        responseValid,                   // Two cycles after request
  output element      responseData,
  output heapError    responseError
);

  arrayId      queryArray;                             // Validator to allocator
  arrayState   queryState;
  logic        grantAvailable;
  arrayId      grantArray;
  logic        allocStrobe;
  logic        freeStrobe;
  arrayId      freeArray;
  logic        storeValid;                             // Validator to store
  storeOp      storeKind;
  arrayId      storeArray;
  elementIndex storeSlot;
  element      storeData;
  heapError    storeError;

  heapAllocator allocator0 (
    .clock, .reset, .allocStrobe, .freeStrobe, .freeArray,
    .queryArray, .queryState, .grantAvailable, .grantArray
  );

  requestValidator validator0 (
    .clock, .reset, .requestValid, .requestOp, .requestArray, .requestIndex,
    .requestData, .queryState, .grantAvailable, .grantArray, .queryArray,
    .allocStrobe, .freeStrobe, .freeArray, .storeValid, .storeKind,
    .storeArray, .storeSlot, .storeData, .storeError
  );

  elementStore store0 (
    .clock, .reset, .storeValid, .storeKind, .storeArray, .storeSlot,
    .storeData, .storeError, .responseValid, .responseData, .responseError
  );

endmodule

// File: logic/elementStore.sv
//------------------
// Element store
// Element memory, read modify write and response register
//------------------

`timescale 1ns/1ps

`include "heapSizes_defs.svh"

module elementStore import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        storeValid,                      // Issue strobe
  input  storeOp      storeKind,
  input  arrayId      storeArray,
  input  elementIndex storeSlot,
  input  element      storeData,
  input  heapError    storeError,
  output logic        responseValid,                   // One cycle response strobe
  output element      responseData,
  output heapError    responseError
);

  element memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];   // Arrays in fixed blocks
  element current;                                     // Addressed element
  element sum;                                         // Wraps at data width

  assign current = memory[storeArray][storeSlot];
  assign sum     = current + storeData;

  always_ff @(posedge clock) begin
    if (reset) begin
      responseValid <= 1'b0;
    end else begin
      responseValid <= storeValid;
    end
  end

  //------------------
  // Memory and response data
  //------------------
  always_ff @(posedge clock) begin
    responseError <= storeError;                       // Decided upstream
    case (storeKind)
      storeWrite: begin
        responseData <= storeData;
        if (storeValid) memory[storeArray][storeSlot] <= storeData;
      end
      storeRead: responseData <= current;              // Read and pop
      storeAdd: begin
        responseData <= sum;                           // New value
        if (storeValid) memory[storeArray][storeSlot] <= sum;
      end
      storeAddAfter: begin
        responseData <= current;                       // Previous value
        if (storeValid) memory[storeArray][storeSlot] <= sum;
      end
      storePass: responseData <= storeData;            // Alloc, size, free, errors
      default:   responseData <= '0;                   // Idle
    endcase
  end

endmodule

// File: logic/requestValidator.sv
//------------------
// Request validator
// Size table, legality checks and issue of
// element operations to the store stage
//------------------

`timescale 1ns/1ps

`include "heapSizes_defs.svh"

module requestValidator import heapPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        requestValid,                    // One cycle request strobe
  input  heapOp       requestOp,
  input  arrayId      requestArray,
  input  elementIndex requestIndex,
  input  element      requestData,
  input  arrayState   queryState,                      // From the allocator
  input  logic        grantAvailable,
  input  arrayId      grantArray,
  output arrayId      queryArray,
  output logic        allocStrobe,
  output logic        freeStrobe,
  output arrayId      freeArray,
  output logic        storeValid,                      // Issue strobe
  output storeOp      storeKind,
  output arrayId      storeArray,
  output elementIndex storeSlot,
  output element      storeData,
  output heapError    storeError
);

  arraySize    sizes [`HEAP_ARRAYS];                   // Current size per array
  arraySize    curSize;                                // Size of requested array
  arraySize    indexSize;                              // Index widened to a size
  arraySize    nextSize;
  heapError    accessError;                            // State check only
  heapError    nextError;
  storeOp      nextKind;
  elementIndex nextSlot;
  element      nextData;
  logic        sizeWrite;                              // Size table update
  logic        allocLegal;
  logic        freeLegal;

  assign queryArray  = requestArray;
  assign freeArray   = requestArray;
  assign curSize     = sizes[requestArray];
  assign indexSize   = {1'b0, requestIndex};
  assign allocStrobe = requestValid && allocLegal;     // Applied at this edge
  assign freeStrobe  = requestValid && freeLegal;

  always_comb begin
    case (queryState)
      stateLive:  accessError = errNone;
      stateFreed: accessError = errFreed;
      default:    accessError = errNeverAllocated;
    endcase
  end

  //------------------
  // Legality and slot choice
  //------------------
  always_comb begin
    nextKind   = storePass;                            // Errors pass data 0
    nextSlot   = requestIndex;
    nextData   = '0;
    nextError  = errNone;
    nextSize   = curSize;
    sizeWrite  = 1'b0;
    allocLegal = 1'b0;
    freeLegal  = 1'b0;
    if (requestOp == opAlloc) begin
      if (grantAvailable) begin
        allocLegal = 1'b1;
        nextData   = element'(grantArray);             // Response carries the array
      end else begin
        nextError = errOutOfMemory;
      end
    end else if (accessError != errNone) begin
      nextError = accessError;                         // Never allocated or freed
    end else begin
      case (requestOp)
        opFree: freeLegal = 1'b1;
        opSize: nextData = element'(curSize);
        opWrite: begin
          nextKind = storeWrite;
          nextData = requestData;
          if (indexSize >= curSize) begin              // Writing past the end grows
            nextSize  = indexSize + 1'b1;
            sizeWrite = 1'b1;
          end
        end
        opRead: begin
          if (indexSize >= curSize) nextError = errOutOfBounds;
          else nextKind = storeRead;
        end
        opAdd: begin
          nextData = requestData;
          if (indexSize >= curSize) nextError = errOutOfBounds;
          else nextKind = storeAdd;
        end
        opAddAfter: begin
          nextData = requestData;
          if (indexSize >= curSize) nextError = errOutOfBounds;
          else nextKind = storeAddAfter;
        end
        opPush: begin
          if (curSize == arraySize'(`HEAP_ARRAY_LENGTH)) begin
            nextError = errFull;
          end else begin
            nextKind  = storeWrite;
            nextSlot  = curSize[`HEAP_INDEX_BITS-1:0]; // Old size
            nextData  = requestData;
            nextSize  = curSize + 1'b1;
            sizeWrite = 1'b1;
          end
        end
        opPop: begin
          if (curSize == '0) begin
            nextError = errEmpty;
          end else begin
            nextKind  = storeRead;
            nextSize  = curSize - 1'b1;
            nextSlot  = nextSize[`HEAP_INDEX_BITS-1:0]; // New size
            sizeWrite = 1'b1;
          end
        end
        default: nextData = '0;
      endcase
      if (nextError != errNone) nextData = '0;         // Errors carry no data
    end
  end

  //------------------
  // Size table and issue
  //------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      storeValid <= 1'b0;
      storeKind  <= storeNone;
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      storeValid <= requestValid;
      storeKind  <= requestValid ? nextKind : storeNone;
      if (allocStrobe) sizes[grantArray] <= '0;        // Granted arrays start empty
      if (requestValid && sizeWrite) sizes[requestArray] <= nextSize;
    end
  end

  always_ff @(posedge clock) begin
    storeArray <= requestArray;                        // Payload
    storeSlot  <= nextSlot;
    storeData  <= nextData;
    storeError <= nextError;
  end

  // Element writes land below the updated size of their array
  slotInRange: assert property (@(posedge clock) disable iff (reset)
    (storeValid && storeKind == storeWrite) |->
      (({1'b0, storeSlot} < sizes[storeArray]) &&
       (sizes[storeArray] <= arraySize'(`HEAP_ARRAY_LENGTH))));

endmodule

// File: logic/heapAllocator.sv
//------------------
// Heap allocator
// Per array state, stack of freed arrays and counter of
// arrays never handed out
//------------------

`timescale 1ns/1ps

`include "heapSizes_defs.svh"

module heapAllocator import heapPkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      allocStrobe,                       // Legal alloc this cycle
  input  logic      freeStrobe,                        // Legal free this cycle
  input  arrayId    freeArray,                         // Array being freed
  input  arrayId    queryArray,                        // Array under validation
  output arrayState queryState,                        // Its current state
  output logic      grantAvailable,                    // An alloc would succeed
  output arrayId    grantArray                         // Array an alloc would get
);

  arrayState states    [`HEAP_ARRAYS];                 // State of each array
  arrayId    freeStack [`HEAP_ARRAYS];                 // Freed arrays for reuse
  logic [`HEAP_ADDRESS_BITS:0] freeTop;                // Entries on the stack
  logic [`HEAP_ADDRESS_BITS:0] newCount;               // Next never used array
  logic      stackEmpty;
  arrayId    topArray;                                 // Most recently freed

  //------------------
  // Grant selection
  //------------------
  assign stackEmpty     = (freeTop == '0);
  assign topArray       = freeStack[arrayId'(freeTop - 1'b1)];
  assign grantAvailable = !stackEmpty || (newCount < `HEAP_ARRAYS); // Reuse before fresh
  assign grantArray     = stackEmpty ? arrayId'(newCount) : topArray;
  assign queryState     = states[queryArray];          // Read by the validator

  //------------------
  // State update
  //------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      freeTop  <= '0;                                  // Stack empty
      newCount <= '0;                                  // Nothing handed out yet
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        states[i] <= stateNever;
      end
    end else begin
      if (allocStrobe) begin
        states[grantArray] <= stateLive;
        if (stackEmpty) begin
          newCount <= newCount + 1'b1;                 // Take a fresh array
        end else begin
          freeTop <= freeTop - 1'b1;                   // Pop the reused array
        end
      end
      if (freeStrobe) begin
        states[freeArray] <= stateFreed;
        freeTop           <= freeTop + 1'b1;           // Push onto stack
      end
    end
  end

  always_ff @(posedge clock) begin
    if (freeStrobe) begin
      freeStack[arrayId'(freeTop)] <= freeArray;       // Stack contents
    end
  end

  // The validator never asks for both in one cycle
  strobesExclusive: assert property (@(posedge clock) disable iff (reset)
    !(allocStrobe && freeStrobe));

  // Frees arrive only after the state check passed in the validator
  freeOnlyLive: assert property (@(posedge clock) disable iff (reset)
    freeStrobe |-> (states[freeArray] == stateLive));

endmodule

// File: logic/heapPkg.sv
//------------------
// Heap package
// Opcodes, error codes, array states and payload types
//------------------

`include "heapSizes_defs.svh"

package heapPkg;

  typedef enum logic [3:0] {
    opAlloc,                                           // Grant a new or reused array
    opFree,                                            // Release an array
    opWrite,                                           // Write an element
    opRead,                                            // Read an element
    opSize,                                            // Current size
    opPush,                                            // Append at the end
    opPop,                                             // Remove from the end
    opAdd,                                             // Add and return the sum
    opAddAfter                                         // Add and return the old value
  } heapOp;

  typedef enum logic [2:0] {
    errNone,
    errNeverAllocated,
    errFreed,
    errOutOfBounds,
    errFull,
    errEmpty,
    errOutOfMemory
  } heapError;

  typedef enum logic [1:0] {stateNever, stateLive, stateFreed} arrayState;

  // Element operation issued to the store stage
  typedef enum logic [2:0] {
    storeNone, storeWrite, storeRead, storeAdd, storeAddAfter, storePass
  } storeOp;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId;      // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex; // Index within an array
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize;    // Zero up to full length
  typedef logic [`HEAP_DATA_BITS-1:0]    element;      // One element

endpackage

// File: include/heapSizes_defs.svh
//------------------
// Heap size macros
// Address, index and data widths and derived counts
//------------------

`ifndef HEAP_SIZES_DEFS_SVH
`define HEAP_SIZES_DEFS_SVH

`define HEAP_ADDRESS_BITS 2                            // Bits in an array number
`define HEAP_INDEX_BITS   2                            // Bits in an element index
`define HEAP_DATA_BITS    12                           // Width of one element

// Derived counts
`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)    // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)      // Elements per array

`endif
